// File: design/dmac_defines.svh
/*
 * DMA controller configuration
 * Bus widths, 2D queue depth and register word offsets
 */

`ifndef DMAC_DEFINES_SVH
`define DMAC_DEFINES_SVH

// Widths
`define DMAC_ADDR_W      32
`define DMAC_DATA_W      32
`define DMAC_LEN_W       16
`define DMAC_REPS_W      16
`define DMAC_ID_W        16
`define DMAC_REG_ADDR_W  3

// Entries in the global 2D request queue
`define DMAC_QUEUE_DEPTH 4

// Register word offsets
`define DMAC_REG_SRC        3'd0
`define DMAC_REG_DST        3'd1
`define DMAC_REG_LEN        3'd2
`define DMAC_REG_SRC_STRIDE 3'd3
`define DMAC_REG_DST_STRIDE 3'd4
`define DMAC_REG_REPS       3'd5
`define DMAC_REG_NEXT_ID    3'd6
`define DMAC_REG_DONE_ID    3'd7

`endif

// File: design/dmac_pkg.sv
/*
 * DMA controller types
 * Scalar widths, stage-to-stage request structs and FSM encodings
 */

`include "dmac_defines.svh"

package dmac_pkg;

  typedef logic [`DMAC_ADDR_W-1:0]     addr_t;
  typedef logic [`DMAC_DATA_W-1:0]     data_t;
  typedef logic [`DMAC_LEN_W-1:0]      len_t;
  typedef logic [`DMAC_REPS_W-1:0]     reps_t;
  typedef logic [`DMAC_ID_W-1:0]       id_t;
  typedef logic [`DMAC_REG_ADDR_W-1:0] reg_addr_t;

  // Register port request
  typedef struct packed {
    reg_addr_t addr;
    logic      we;
    data_t     wdata;
  } reg_req_t;

  // One 2D transfer, strides are in bytes
  typedef struct packed {
    addr_t src;
    addr_t dst;
    len_t  len;
    addr_t src_stride;
    addr_t dst_stride;
    reps_t reps;
  } nd_req_t;

  // One 1D burst, last marks the final row of its 2D transfer
  typedef struct packed {
    addr_t src;
    addr_t dst;
    len_t  len;
    logic  last;
  } burst_req_t;

  typedef struct packed {
    addr_t addr;
    logic  we;
    data_t wdata;
  } mem_req_t;

  typedef enum logic {MID_IDLE, MID_ISSUE} midend_state_e;

  typedef enum logic [1:0] {BE_IDLE, BE_READ, BE_WAIT_DATA, BE_WRITE} backend_state_e;

endpackage

// File: design/dmac_reg_frontend.sv
/*
 * Register frontend
 * Holds the transfer descriptor and launches it on a NEXT_ID read
 */

`include "dmac_defines.svh"

module dmac_reg_frontend (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  dmac_pkg::reg_req_t  reg_req_i,
  input  logic                reg_valid_i,
  output logic                reg_ready_o,
  output dmac_pkg::data_t     reg_rdata_o,
  output logic                reg_rvalid_o,
  output dmac_pkg::nd_req_t   req_o,
  output logic                req_valid_o,
  input  logic                req_ready_i,
  input  logic                xfer_done_i
);

  dmac_pkg::addr_t src_q;
  dmac_pkg::addr_t dst_q;
  dmac_pkg::len_t  len_q;
  dmac_pkg::addr_t src_stride_q;
  dmac_pkg::addr_t dst_stride_q;
  dmac_pkg::reps_t reps_q;
  dmac_pkg::id_t   next_id_q;
  dmac_pkg::id_t   done_id_q;

  dmac_pkg::data_t rdata_d;
  logic            is_launch;
  logic            reg_accept;
  logic            reg_write;

  // ----------------------------------------
  // Handshake and launch
  // ----------------------------------------

  // A NEXT_ID read stalls until the queue can take the descriptor
  assign is_launch   = reg_valid_i & ~reg_req_i.we & (reg_req_i.addr == `DMAC_REG_NEXT_ID);
  assign reg_ready_o = ~is_launch | req_ready_i;
  assign reg_accept  = reg_valid_i & reg_ready_o;
  assign reg_write   = reg_accept & reg_req_i.we;

  assign req_valid_o      = is_launch;
  assign req_o.src        = src_q;
  assign req_o.dst        = dst_q;
  assign req_o.len        = len_q;
  assign req_o.src_stride = src_stride_q;
  assign req_o.dst_stride = dst_stride_q;
  assign req_o.reps       = reps_q;

  // ----------------------------------------
  // Read mux
  // ----------------------------------------

  always_comb begin
    case (reg_req_i.addr)
      `DMAC_REG_SRC:        rdata_d = src_q;
      `DMAC_REG_DST:        rdata_d = dst_q;
      `DMAC_REG_LEN:        rdata_d = dmac_pkg::data_t'(len_q);
      `DMAC_REG_SRC_STRIDE: rdata_d = src_stride_q;
      `DMAC_REG_DST_STRIDE: rdata_d = dst_stride_q;
      `DMAC_REG_REPS:       rdata_d = dmac_pkg::data_t'(reps_q);
      // ID of the transfer being launched
      `DMAC_REG_NEXT_ID:    rdata_d = dmac_pkg::data_t'(next_id_q + dmac_pkg::id_t'(1));
      default:              rdata_d = dmac_pkg::data_t'(done_id_q);
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      src_q        <= '0;
      dst_q        <= '0;
      len_q        <= '0;
      src_stride_q <= '0;
      dst_stride_q <= '0;
      reps_q       <= '0;
    end else if (reg_write) begin
      case (reg_req_i.addr)
        `DMAC_REG_SRC:        src_q        <= reg_req_i.wdata;
        `DMAC_REG_DST:        dst_q        <= reg_req_i.wdata;
        `DMAC_REG_LEN:        len_q        <= reg_req_i.wdata[`DMAC_LEN_W-1:0];
        `DMAC_REG_SRC_STRIDE: src_stride_q <= reg_req_i.wdata;
        `DMAC_REG_DST_STRIDE: dst_stride_q <= reg_req_i.wdata;
        `DMAC_REG_REPS:       reps_q       <= reg_req_i.wdata[`DMAC_REPS_W-1:0];
        default:              ;
      endcase
    end
  end

  // ID counters and response strobe
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      next_id_q    <= '0;
      done_id_q    <= '0;
      reg_rvalid_o <= 1'b0;
    end else begin
      reg_rvalid_o <= reg_accept;
      if (is_launch && req_ready_i) begin
        next_id_q <= next_id_q + dmac_pkg::id_t'(1);
      end
      if (xfer_done_i) begin
        done_id_q <= done_id_q + dmac_pkg::id_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reg_accept) begin
      reg_rdata_o <= rdata_d;
    end
  end

endmodule

// File: design/dmac_req_queue.sv
/*
 * Global 2D request FIFO between register frontend and midend
 */

module dmac_req_queue #(
  parameter int unsigned DEPTH = 4
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  dmac_pkg::nd_req_t  req_i,
  input  logic               valid_i,
  output logic               ready_o,
  output dmac_pkg::nd_req_t  req_o,
  output logic               valid_o,
  input  logic               ready_i
);

  localparam int unsigned PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CntW = $clog2(DEPTH) + 1;

  dmac_pkg::nd_req_t mem_q [DEPTH];
  logic [PtrW-1:0]   wptr_q;
  logic [PtrW-1:0]   rptr_q;
  logic [CntW-1:0]   count_q;
  logic              push;
  logic              pop;

  assign ready_o = (count_q != CntW'(DEPTH));
  assign valid_o = (count_q != '0);
  assign req_o   = mem_q[rptr_q];
  assign push    = valid_i & ready_o;
  assign pop     = valid_o & ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        wptr_q <= (wptr_q == PtrW'(DEPTH - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == PtrW'(DEPTH - 1)) ? '0 : rptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= req_i;
    end
  end

endmodule

// File: design/dmac_twod_midend.sv
/*
 * 2D midend
 * Splits each 2D request into one 1D burst per repetition
 */

module dmac_twod_midend (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  dmac_pkg::nd_req_t    nd_req_i,
  input  logic                 nd_valid_i,
  output logic                 nd_ready_o,
  output dmac_pkg::burst_req_t burst_o,
  output logic                 burst_valid_o,
  input  logic                 burst_ready_i,
  input  logic                 burst_done_i,
  input  logic                 burst_last_i,
  output logic                 xfer_done_o,
  output logic                 busy_o
);

  dmac_pkg::midend_state_e state_q;
  dmac_pkg::reps_t         reps_left_q;
  dmac_pkg::addr_t         src_q;
  dmac_pkg::addr_t         dst_q;
  dmac_pkg::addr_t         src_stride_q;
  dmac_pkg::addr_t         dst_stride_q;
  dmac_pkg::len_t          len_q;
  // 2D transfers whose last burst went to the backend
  logic [2:0]              outstanding_q;

  logic nd_accept;
  logic burst_accept;
  logic is_last;

  assign nd_ready_o    = (state_q == dmac_pkg::MID_IDLE);
  assign nd_accept     = nd_valid_i & nd_ready_o;
  assign burst_valid_o = (state_q == dmac_pkg::MID_ISSUE);
  assign burst_accept  = burst_valid_o & burst_ready_i;
  assign is_last       = (reps_left_q <= dmac_pkg::reps_t'(1));

  assign burst_o.src  = src_q;
  assign burst_o.dst  = dst_q;
  assign burst_o.len  = len_q;
  assign burst_o.last = is_last;

  assign xfer_done_o = burst_done_i & burst_last_i;
  assign busy_o      = (state_q == dmac_pkg::MID_ISSUE) | (outstanding_q != '0);

  // ----------------------------------------
  // Rep walker
  // ----------------------------------------

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= dmac_pkg::MID_IDLE;
      reps_left_q <= '0;
    end else begin
      case (state_q)
        dmac_pkg::MID_IDLE: begin
          if (nd_accept) begin
            state_q     <= dmac_pkg::MID_ISSUE;
            // Zero reps behaves like a single row
            reps_left_q <= (nd_req_i.reps == '0) ? dmac_pkg::reps_t'(1) : nd_req_i.reps;
          end
        end
        dmac_pkg::MID_ISSUE: begin
          if (burst_accept) begin
            if (is_last) begin
              state_q <= dmac_pkg::MID_IDLE;
            end else begin
              reps_left_q <= reps_left_q - dmac_pkg::reps_t'(1);
            end
          end
        end
        default: state_q <= dmac_pkg::MID_IDLE;
      endcase
    end
  end

  // Running row addresses
  always_ff @(posedge clk_i) begin
    if (nd_accept) begin
      src_q        <= nd_req_i.src;
      dst_q        <= nd_req_i.dst;
      len_q        <= nd_req_i.len;
      src_stride_q <= nd_req_i.src_stride;
      dst_stride_q <= nd_req_i.dst_stride;
    end else if (burst_accept) begin
      src_q <= src_q + src_stride_q;
      dst_q <= dst_q + dst_stride_q;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      outstanding_q <= '0;
    end else begin
      case ({burst_accept & is_last, xfer_done_o})
        2'b10:   outstanding_q <= outstanding_q + 1'b1;
        2'b01:   outstanding_q <= outstanding_q - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

// File: design/dmac_copy_backend.sv
/*
 * Copy backend
 * Moves a 1D burst word by word, read then write, over one memory port
 */

`include "dmac_defines.svh"

module dmac_copy_backend (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  dmac_pkg::burst_req_t burst_i,
  input  logic                 burst_valid_i,
  output logic                 burst_ready_o,
  output logic                 burst_done_o,
  output logic                 burst_last_o,
  output dmac_pkg::mem_req_t   mem_req_o,
  output logic                 mem_valid_o,
  input  logic                 mem_ready_i,
  input  dmac_pkg::data_t      mem_rdata_i,
  input  logic                 mem_rvalid_i
);

  localparam dmac_pkg::addr_t WordBytes = dmac_pkg::addr_t'(`DMAC_DATA_W / 8);

  dmac_pkg::backend_state_e state_q;
  dmac_pkg::len_t           words_left_q;
  dmac_pkg::addr_t          src_addr_q;
  dmac_pkg::addr_t          dst_addr_q;
  dmac_pkg::data_t          data_q;
  logic                     last_q;
  logic                     done_q;

  logic burst_accept;
  logic rd_data;
  logic wr_accept;

  assign burst_ready_o = (state_q == dmac_pkg::BE_IDLE);
  assign burst_accept  = burst_valid_i & burst_ready_o;
  assign rd_data       = (state_q == dmac_pkg::BE_WAIT_DATA) & mem_rvalid_i;
  assign wr_accept     = (state_q == dmac_pkg::BE_WRITE) & mem_ready_i;

  assign burst_done_o = done_q;
  assign burst_last_o = last_q;

  // ----------------------------------------
  // Memory port
  // ----------------------------------------

  // Driven from registers only, so it holds while stalled
  assign mem_valid_o     = (state_q == dmac_pkg::BE_READ) | (state_q == dmac_pkg::BE_WRITE);
  assign mem_req_o.we    = (state_q == dmac_pkg::BE_WRITE);
  assign mem_req_o.addr  = mem_req_o.we ? dst_addr_q : src_addr_q;
  assign mem_req_o.wdata = data_q;

  // ----------------------------------------
  // Word loop
  // ----------------------------------------

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q      <= dmac_pkg::BE_IDLE;
      words_left_q <= '0;
      last_q       <= 1'b0;
      done_q       <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        dmac_pkg::BE_IDLE: begin
          if (burst_accept) begin
            last_q       <= burst_i.last;
            words_left_q <= burst_i.len;
            // Empty burst, report right away
            if (burst_i.len == '0) begin
              done_q <= 1'b1;
            end else begin
              state_q <= dmac_pkg::BE_READ;
            end
          end
        end
        dmac_pkg::BE_READ: begin
          if (mem_ready_i) begin
            state_q <= dmac_pkg::BE_WAIT_DATA;
          end
        end
        dmac_pkg::BE_WAIT_DATA: begin
          if (mem_rvalid_i) begin
            state_q <= dmac_pkg::BE_WRITE;
          end
        end
        dmac_pkg::BE_WRITE: begin
          if (mem_ready_i) begin
            words_left_q <= words_left_q - dmac_pkg::len_t'(1);
            if (words_left_q == dmac_pkg::len_t'(1)) begin
              state_q <= dmac_pkg::BE_IDLE;
              done_q  <= 1'b1;
            end else begin
              state_q <= dmac_pkg::BE_READ;
            end
          end
        end
        default: state_q <= dmac_pkg::BE_IDLE;
      endcase
    end
  end

  // Addresses and the word in flight
  always_ff @(posedge clk_i) begin
    if (burst_accept) begin
      src_addr_q <= burst_i.src;
      dst_addr_q <= burst_i.dst;
    end else if (wr_accept) begin
      src_addr_q <= src_addr_q + WordBytes;
      dst_addr_q <= dst_addr_q + WordBytes;
    end
    if (rd_data) begin
      data_q <= mem_rdata_i;
    end
  end

endmodule

// File: design/dmac_top.sv
/*
 * 2D DMA controller top
 * Frontend, request queue, 2D midend and copy backend in a chain
 */

`include "dmac_defines.svh"

module dmac_top (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  dmac_pkg::reg_req_t reg_req_i,
  input  logic               reg_valid_i,
  output logic               reg_ready_o,
  output dmac_pkg::data_t    reg_rdata_o,
  output logic               reg_rvalid_o,
  output dmac_pkg::mem_req_t mem_req_o,
  output logic               mem_valid_o,
  input  logic               mem_ready_i,
  input  dmac_pkg::data_t    mem_rdata_i,
  input  logic               mem_rvalid_i,
  output logic               done_o,
  output logic               busy_o
);

  dmac_pkg::nd_req_t    fe_req;
  dmac_pkg::nd_req_t    queue_req;
  dmac_pkg::burst_req_t burst_req;
  logic                 fe_valid;
  logic                 fe_ready;
  logic                 queue_valid;
  logic                 queue_ready;
  logic                 be_valid;
  logic                 be_ready;
  logic                 burst_done;
  logic                 burst_last;

  // ----------------------------------------
  // Frontend and 2D queue
  // ----------------------------------------

  dmac_reg_frontend u_frontend (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .reg_req_i    (reg_req_i),
    .reg_valid_i  (reg_valid_i),
    .reg_ready_o  (reg_ready_o),
    .reg_rdata_o  (reg_rdata_o),
    .reg_rvalid_o (reg_rvalid_o),
    .req_o        (fe_req),
    .req_valid_o  (fe_valid),
    .req_ready_i  (fe_ready),
    .xfer_done_i  (done_o)
  );

  dmac_req_queue #(
    .DEPTH (`DMAC_QUEUE_DEPTH)
  ) u_queue (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (fe_req),
    .valid_i  (fe_valid),
    .ready_o  (fe_ready),
    .req_o    (queue_req),
    .valid_o  (queue_valid),
    .ready_i  (queue_ready)
  );

  // ----------------------------------------
  // Midend and backend
  // ----------------------------------------

  dmac_twod_midend u_midend (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .nd_req_i      (queue_req),
    .nd_valid_i    (queue_valid),
    .nd_ready_o    (queue_ready),
    .burst_o       (burst_req),
    .burst_valid_o (be_valid),
    .burst_ready_i (be_ready),
    .burst_done_i  (burst_done),
    .burst_last_i  (burst_last),
    .xfer_done_o   (done_o),
    .busy_o        (busy_o)
  );

  dmac_copy_backend u_backend (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .burst_i       (burst_req),
    .burst_valid_i (be_valid),
    .burst_ready_o (be_ready),
    .burst_done_o  (burst_done),
    .burst_last_o  (burst_last),
    .mem_req_o     (mem_req_o),
    .mem_valid_o   (mem_valid_o),
    .mem_ready_i   (mem_ready_i),
    .mem_rdata_i   (mem_rdata_i),
    .mem_rvalid_i  (mem_rvalid_i)
  );

endmodule

// File: verification/dmac_tb.sv
/*
 * Testbench for the 2D DMA controller
 * Runs the commands of a stimulus file against a stalling memory model
 */

`include "dmac_defines.svh"

module dmac_tb;

  timeunit 1ns;
  timeprecision 1ps;

  // About 50 commands and 26 copied words, each well under 200 cycles with stalls
  localparam int MAX_CYCLES = 20000;

  logic                 clk_i = 1'b0;
  logic                 arst_n_i;
  dmac_pkg::reg_req_t   reg_req_i;
  logic                 reg_valid_i;
  logic                 reg_ready_o;
  dmac_pkg::data_t      reg_rdata_o;
  logic                 reg_rvalid_o;
  dmac_pkg::mem_req_t   mem_req_o;
  logic                 mem_valid_o;
  logic                 mem_ready_i;
  dmac_pkg::data_t      mem_rdata_i;
  logic                 mem_rvalid_i;
  logic                 done_o;
  logic                 busy_o;

  dmac_pkg::data_t mem [dmac_pkg::addr_t];
  integer          seed = 32'he105;
  int              cycles = 0;
  int              done_pulses = 0;
  int              launches = 0;
  int              errors = 0;
  int              test_errors = 0;
  int              tests = 0;
  int              tests_failed = 0;

  dmac_top u_dut (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .reg_req_i    (reg_req_i),
    .reg_valid_i  (reg_valid_i),
    .reg_ready_o  (reg_ready_o),
    .reg_rdata_o  (reg_rdata_o),
    .reg_rvalid_o (reg_rvalid_o),
    .mem_req_o    (mem_req_o),
    .mem_valid_o  (mem_valid_o),
    .mem_ready_i  (mem_ready_i),
    .mem_rdata_i  (mem_rdata_i),
    .mem_rvalid_i (mem_rvalid_i),
    .done_o       (done_o),
    .busy_o       (busy_o)
  );

  always #4 clk_i = ~clk_i;

  // Done pulse count and run limit
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (done_o) begin
      done_pulses <= done_pulses + 1;
    end
    if (cycles == MAX_CYCLES) begin
      $display("Run timed out after %0d cycles, a wait never finished", MAX_CYCLES);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR @%0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  // Unwritten words read a pattern of their own address
  function automatic dmac_pkg::data_t read_word(input dmac_pkg::addr_t addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return addr ^ 32'hc0de_0000;
  endfunction

  // ----------------------------------------
  // Memory model
  // ----------------------------------------

  initial begin : memory_model
    dmac_pkg::data_t    rd_word;
    dmac_pkg::mem_req_t held;
    int unsigned        delay;
    logic               stalled;
    mem_ready_i  = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    rd_word      = '0;
    delay        = 0;
    stalled      = 1'b0;
    forever begin
      @(posedge clk_i);
      // A stalled request must not move
      if (stalled) begin
        check("mem_req_o.addr under stall", mem_req_o.addr, held.addr);
        check("mem_req_o.wdata under stall", mem_req_o.wdata, held.wdata);
        check("mem valid and we under stall", {mem_valid_o, mem_req_o.we}, {1'b1, held.we});
      end
      stalled = mem_valid_o && !mem_ready_i;
      held    = mem_req_o;
      mem_rvalid_i <= 1'b0;
      if (delay != 0) begin
        delay = delay - 1;
        if (delay == 0) begin
          mem_rvalid_i <= 1'b1;
          mem_rdata_i  <= rd_word;
        end
      end
      if (mem_valid_o && mem_ready_i) begin
        if (mem_req_o.we) begin
          mem[mem_req_o.addr] = mem_req_o.wdata;
        end else begin
          rd_word = read_word(mem_req_o.addr);
          delay   = 1 + ($unsigned($random(seed)) % 3);
        end
      end
      // Stall roughly one cycle in four
      mem_ready_i <= (($random(seed) & 3) != 0);
    end
  end

  // ----------------------------------------
  // Register port and command helpers
  // ----------------------------------------

  task automatic reg_access(input logic we, input logic [2:0] off, input dmac_pkg::data_t wdata,
                            output dmac_pkg::data_t rdata);
    @(posedge clk_i);
    reg_req_i.addr  <= off;
    reg_req_i.we    <= we;
    reg_req_i.wdata <= wdata;
    reg_valid_i     <= 1'b1;
    @(posedge clk_i);
    while (!reg_ready_o) begin
      @(posedge clk_i);
    end
    check("reg_rvalid_o in the accept cycle", reg_rvalid_o, 1'b0);
    reg_valid_i <= 1'b0;
    @(posedge clk_i);
    check("reg_rvalid_o one cycle after accept", reg_rvalid_o, 1'b1);
    rdata = reg_rdata_o;
  endtask

  // Until every launch has a done pulse and the engine is idle
  task automatic wait_idle();
    @(posedge clk_i);
    while (done_pulses < launches || busy_o) begin
      @(posedge clk_i);
    end
  endtask

  task automatic end_test(input logic [8*24-1:0] name);
    tests++;
    if (test_errors == 0) begin
      $display("Test %0s: ok", name);
    end else begin
      $display("Test %0s: failed with %0d errors", name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  initial begin
    int                 fd;
    int                 code;
    logic [7:0]         cmd;
    dmac_pkg::data_t    a;
    dmac_pkg::data_t    d;
    dmac_pkg::data_t    rd;
    logic [8*24-1:0]    name;
    logic [8*128-1:0]   line;
    arst_n_i    = 1'b0;
    reg_req_i   = '0;
    reg_valid_i = 1'b0;
    repeat (2) @(posedge clk_i);
    // Outputs in reset
    check("reg_ready_o in reset", reg_ready_o, 1'b1);
    check("reg_rvalid_o in reset", reg_rvalid_o, 1'b0);
    check("mem_valid_o in reset", mem_valid_o, 1'b0);
    check("done_o in reset", done_o, 1'b0);
    check("busy_o in reset", busy_o, 1'b0);
    arst_n_i <= 1'b1;
    fd = $fopen("verification/dmac_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file verification/dmac_input.txt");
      $display("FAIL: see errors above");
      $finish;
    end else begin
      while ($fscanf(fd, " %c", cmd) == 1) begin
        case (cmd)
          "#": code = $fgets(line, fd);
          "M": begin
            code = $fscanf(fd, "%h %h", a, d);
            mem[a] = d;
          end
          "W": begin
            code = $fscanf(fd, "%h %h", a, d);
            reg_access(1'b1, a[2:0], d, rd);
          end
          "R": begin
            code = $fscanf(fd, "%h %h", a, d);
            reg_access(1'b0, a[2:0], '0, rd);
            check($sformatf("register %0d", a), rd, d);
          end
          "L": begin
            code = $fscanf(fd, "%h", d);
            reg_access(1'b0, `DMAC_REG_NEXT_ID, '0, rd);
            launches++;
            check("launched ID", rd, d);
          end
          "I": begin
            wait_idle();
            check("done_o pulse count", done_pulses, launches);
          end
          "C": begin
            code = $fscanf(fd, "%h %h", a, d);
            check($sformatf("memory word %h", a), read_word(a), d);
          end
          "E": begin
            code = $fscanf(fd, "%s", name);
            end_test(name);
          end
          default: begin
            $display("Unknown command %c in the stimulus file", cmd);
            errors++;
          end
        endcase
      end
      $fclose(fd);
      $display("Tests run %0d, failed %0d, errors %0d", tests, tests_failed, errors);
      if (errors == 0) begin
        $display("PASS: all tests");
      end else begin
        $display("FAIL: see errors above");
      end
      $finish;
    end
  end

endmodule

// File: verification/dmac_input.txt
# Columns: M addr data | W off data | R off expect | L id | I | C addr expect | E name
# Values in hex, unwritten memory reads as addr ^ c0de0000
W 0 00001000
W 1 00002000
W 2 00000008
W 3 00000040
W 4 00000010
W 5 00000001
R 0 00001000
R 3 00000040
R 5 00000001
R 7 00000000
E regs
M 1000 11111111
M 1004 22222222
L 0001
I
C 2000 11111111
C 2004 22222222
C 2008 c0de1008
C 201c c0de101c
C 2020 c0de2020
E copy_1d
W 0 00003000
W 1 00004000
W 2 00000004
W 5 00000003
L 0002
I
C 4000 c0de3000
C 4010 c0de3040
C 401c c0de304c
C 402c c0de308c
C 4030 c0de4030
E copy_2d
W 0 00005000
W 1 00006000
W 2 00000002
W 5 00000001
L 0003
W 1 00006010
L 0004
W 1 00006020
L 0005
I
R 7 00000005
C 6000 c0de5000
C 6024 c0de5004
E back_to_back
W 1 00008000
W 2 00000000
M 8000 deadbeef
L 0006
I
C 8000 deadbeef
R 7 00000006
E zero_len

// File: sim.f
+incdir+design
design/dmac_pkg.sv
design/dmac_reg_frontend.sv
design/dmac_req_queue.sv
design/dmac_twod_midend.sv
design/dmac_copy_backend.sv
design/dmac_top.sv
verification/dmac_tb.sv
